// ==== include/ps2_params.svh ====
`ifndef PS2_PARAMS_SVH
`define PS2_PARAMS_SVH

// --------------------------------------------------
// frame format
// --------------------------------------------------
`define PS2_FRAME_BITS 11 // start + 8 data + parity + stop

// --------------------------------------------------
// special scan codes
// --------------------------------------------------
`define PS2_EXTEND_CODE  8'hE0 // prefix for extended keys
`define PS2_RELEASE_CODE 8'hF0 // break prefix, key let go
`define PS2_LEFT_SHIFT   8'h12
`define PS2_RIGHT_SHIFT  8'h59

// idle timeout, roughly 60 us at 49 MHz
`define PS2_WATCHDOG_CYCLES 2950
`define PS2_WATCHDOG_BITS   12 // wide enough to hold the count above

`define PS2_UNKNOWN_ASCII 8'h2E // '.' for keys outside the table

`endif

// ==== design/ps2_frame_pkg.sv ====
`default_nettype none

`include "ps2_params.svh"

// line-level types, what comes off the ps2 wires
package ps2_frame_pkg;

  typedef logic [`PS2_FRAME_BITS-1:0] frame_t; // raw frame, start bit ends in bit 0
  typedef logic [7:0] scan_code_t;             // data byte of one frame
  typedef logic [3:0] bit_count_t;             // falling edges seen so far

  // follows the keyboard clock, markers last one system clock
  typedef enum logic [1:0] {
    rx_clk_h       = 2'd0, // line high, watchdog running
    rx_falling_mrk = 2'd1, // sample data here
    rx_clk_l       = 2'd2, // line low
    rx_rising_mrk  = 2'd3
  } rx_state_t;

endpackage

`default_nettype wire

// ==== design/ps2_key_pkg.sv ====
`default_nettype none

// key-level types, what the host sees
package ps2_key_pkg;

  typedef logic [7:0] ascii_t;

  // --------------------------------------------------
  // one decoded key event
  // --------------------------------------------------
  // extended and released come from prefixes that arrived
  // before the scan code, not from the code itself
  typedef struct packed {
    logic                     extended;  // 0xE0 seen before this code
    logic                     released;  // 0xF0 seen, key was let go
    ps2_frame_pkg::scan_code_t scan_code;
    ascii_t                   ascii;     // '.' when not in the table
  } key_event_t;

endpackage

`default_nettype wire

// ==== design/ps2_ascii_map.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module ps2_ascii_map (
  input  ps2_frame_pkg::scan_code_t scan_code,
  input  logic                      shift_key_on,
  output ps2_key_pkg::ascii_t       ascii
);

  // --------------------------------------------------
  // set 2 make codes to ascii, kept keys only
  // --------------------------------------------------
  always_comb
  begin
    ascii = `PS2_UNKNOWN_ASCII; // also what a shifted digit gives
    case (scan_code)
      8'h1C: ascii = 8'h61; // a
      8'h32: ascii = 8'h62;
      8'h21: ascii = 8'h63;
      8'h23: ascii = 8'h64;
      8'h24: ascii = 8'h65;
      8'h2B: ascii = 8'h66;
      8'h34: ascii = 8'h67;
      8'h33: ascii = 8'h68;
      8'h43: ascii = 8'h69;
      8'h3B: ascii = 8'h6A;
      8'h42: ascii = 8'h6B;
      8'h4B: ascii = 8'h6C;
      8'h3A: ascii = 8'h6D;
      8'h31: ascii = 8'h6E;
      8'h44: ascii = 8'h6F;
      8'h4D: ascii = 8'h70;
      8'h15: ascii = 8'h71;
      8'h2D: ascii = 8'h72;
      8'h1B: ascii = 8'h73;
      8'h2C: ascii = 8'h74;
      8'h3C: ascii = 8'h75;
      8'h2A: ascii = 8'h76;
      8'h1D: ascii = 8'h77;
      8'h22: ascii = 8'h78;
      8'h35: ascii = 8'h79;
      8'h1A: ascii = 8'h7A; // z
      8'h45: if (!shift_key_on) ascii = 8'h30; // 0, digits only unshifted
      8'h16: if (!shift_key_on) ascii = 8'h31;
      8'h1E: if (!shift_key_on) ascii = 8'h32;
      8'h26: if (!shift_key_on) ascii = 8'h33;
      8'h25: if (!shift_key_on) ascii = 8'h34;
      8'h2E: if (!shift_key_on) ascii = 8'h35;
      8'h36: if (!shift_key_on) ascii = 8'h36;
      8'h3D: if (!shift_key_on) ascii = 8'h37;
      8'h3E: if (!shift_key_on) ascii = 8'h38;
      8'h46: if (!shift_key_on) ascii = 8'h39; // 9
      // control keys, same in both shift states
      8'h66: ascii = 8'h08; // backspace
      8'h0D: ascii = 8'h09; // tab
      8'h5A: ascii = 8'h0D; // enter
      8'h76: ascii = 8'h1B; // escape
      8'h29: ascii = 8'h20; // space
      default: ;
    endcase
    if (shift_key_on && ascii >= 8'h61 && ascii <= 8'h7A)
      ascii = ascii - 8'h20; // upper case sits 0x20 lower
  end

endmodule

`default_nettype wire

// ==== design/ps2_rx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module ps2_rx_frame (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      ps2_clk,
  input  logic                      ps2_data,
  output logic                      frame_done,
  output ps2_frame_pkg::scan_code_t scan_code
);

  localparam ps2_frame_pkg::bit_count_t frame_bits = `PS2_FRAME_BITS;
  localparam logic [`PS2_WATCHDOG_BITS-1:0] watchdog_last = `PS2_WATCHDOG_CYCLES - 1;

  logic                       ps2_clk_s;  // synchronized line clock
  logic                       ps2_data_s; // synchronized line data
  ps2_frame_pkg::rx_state_t   state;
  ps2_frame_pkg::rx_state_t   state_next;
  ps2_frame_pkg::bit_count_t  bit_count;
  ps2_frame_pkg::frame_t      frame;
  logic [`PS2_WATCHDOG_BITS-1:0] watchdog_count;
  logic                       watchdog_done;

  // --------------------------------------------------
  // input synchronizer
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ps2_clk_s  <= 1'b1; // lines idle high
      ps2_data_s <= 1'b1;
    end
    else
    begin
      ps2_clk_s  <= ps2_clk;
      ps2_data_s <= ps2_data;
    end
  end

  // --------------------------------------------------
  // receive fsm, tracks the keyboard clock
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_frame_pkg::rx_clk_h;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      ps2_frame_pkg::rx_clk_h:
        if (!ps2_clk_s) state_next = ps2_frame_pkg::rx_falling_mrk;
      ps2_frame_pkg::rx_falling_mrk:
        state_next = ps2_frame_pkg::rx_clk_l;  // single cycle
      ps2_frame_pkg::rx_clk_l:
        if (ps2_clk_s) state_next = ps2_frame_pkg::rx_rising_mrk;
      ps2_frame_pkg::rx_rising_mrk:
        state_next = ps2_frame_pkg::rx_clk_h;
      default:
        state_next = ps2_frame_pkg::rx_clk_h;
    endcase
  end

  // watchdog runs only while the line clock sits high
  always_ff @(posedge clk)
  begin
    if (reset || state == ps2_frame_pkg::rx_falling_mrk
        || state == ps2_frame_pkg::rx_rising_mrk)
      watchdog_count <= '0;
    else if (state == ps2_frame_pkg::rx_clk_h && !watchdog_done)
      watchdog_count <= watchdog_count + 1'b1; // saturates at the limit
  end
  assign watchdog_done = (watchdog_count == watchdog_last);

  // bit counter, frame_done has priority so the count wraps after 11
  always_ff @(posedge clk)
  begin
    if (reset || frame_done)
      bit_count <= '0;
    else if (watchdog_done && state == ps2_frame_pkg::rx_clk_h && ps2_clk_s)
      bit_count <= '0; // stalled frame, e.g. hot plug
    else if (state == ps2_frame_pkg::rx_falling_mrk)
      bit_count <= bit_count + 1'b1;
  end

  // new bit enters at the top, start bit ends up in bit 0
  always_ff @(posedge clk)
  begin
    if (state == ps2_frame_pkg::rx_falling_mrk)
      frame <= {ps2_data_s, frame[`PS2_FRAME_BITS-1:1]};
  end

  assign frame_done = (bit_count == frame_bits);
  assign scan_code  = frame[8:1]; // data byte sits between start and parity

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_count_range: assert property (@(posedge clk) disable iff (reset)
    bit_count <= frame_bits);
  a_done_single: assert property (@(posedge clk) disable iff (reset)
    frame_done |=> !frame_done);

endmodule

`default_nettype wire

// ==== design/ps2_key_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module ps2_key_decoder #(
  parameter int trap_shift_keys = 0 // nonzero: shift keys give no event
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      frame_done,
  input  ps2_frame_pkg::scan_code_t scan_code,
  input  logic                      rx_read,
  output ps2_key_pkg::key_event_t   key_event,
  output logic                      shift_key_on,
  output logic                      data_ready
);

  typedef enum logic {
    ready_idle = 1'b0,
    ready_full = 1'b1
  } ready_state_t;

  ready_state_t        ready_state;
  logic                is_extend;
  logic                is_release;
  logic                is_shift;
  logic                output_event;  // ordinary code, clears the holds
  logic                output_strobe; // ordinary code that is reported
  logic                hold_extended;
  logic                hold_released;
  logic                left_shift_key;
  logic                right_shift_key;
  ps2_key_pkg::ascii_t ascii;

  assign is_extend  = (scan_code == `PS2_EXTEND_CODE);
  assign is_release = (scan_code == `PS2_RELEASE_CODE);
  assign is_shift   = (scan_code == `PS2_LEFT_SHIFT) || (scan_code == `PS2_RIGHT_SHIFT);

  assign output_event  = frame_done && !is_extend && !is_release;
  assign output_strobe = output_event && ((trap_shift_keys == 0) || !is_shift);

  // --------------------------------------------------
  // prefix holding
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || output_event)
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_done)
    begin
      if (is_extend) hold_extended <= 1'b1;
      if (is_release) hold_released <= 1'b1;
    end
  end

  // shift keys, make sets and break clears
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift_key  <= 1'b0;
      right_shift_key <= 1'b0;
    end
    else if (frame_done)
    begin
      if (scan_code == `PS2_LEFT_SHIFT) left_shift_key <= !hold_released;
      if (scan_code == `PS2_RIGHT_SHIFT) right_shift_key <= !hold_released;
    end
  end
  assign shift_key_on = left_shift_key || right_shift_key;

  // table sees the shift state from before this frame
  ps2_ascii_map i_ascii_map (
    .scan_code    (scan_code),
    .shift_key_on (shift_key_on),
    .ascii        (ascii)
  );

  // --------------------------------------------------
  // output register and ready fsm
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      key_event <= '0;
    else if (output_strobe)
    begin
      key_event.extended  <= hold_extended;
      key_event.released  <= hold_released;
      key_event.scan_code <= scan_code;
      key_event.ascii     <= ascii;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      ready_state <= ready_idle;
    else if (output_strobe)
      ready_state <= ready_full; // newer key overwrites, stays ready
    else if (rx_read)
      ready_state <= ready_idle;
  end
  assign data_ready = (ready_state == ready_full);

  // ready must hold until the host reads
  a_ready_hold: assert property (@(posedge clk) disable iff (reset)
    data_ready && !rx_read |=> data_ready);

endmodule

`default_nettype wire

// ==== design/ps2_keyboard_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx #(
  parameter int trap_shift_keys = 0 // nonzero: shift keys move only the shift status
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ps2_clk,  // keyboard clock, input only
  input  logic                    ps2_data, // keyboard data, input only
  input  logic                    rx_read,  // host read strobe
  output ps2_key_pkg::key_event_t rx_event,
  output logic                    rx_shift_key_on,
  output logic                    rx_data_ready
);

  logic                      frame_done; // one pulse per complete frame
  ps2_frame_pkg::scan_code_t scan_code;  // valid with frame_done

  // line side, synchronizer and frame shifter
  ps2_rx_frame i_rx_frame (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame_done (frame_done),
    .scan_code  (scan_code)
  );

  // key side, prefixes, shift and ready level
  ps2_key_decoder #(
    .trap_shift_keys (trap_shift_keys)
  ) i_key_decoder (
    .clk          (clk),
    .reset        (reset),
    .frame_done   (frame_done),
    .scan_code    (scan_code),
    .rx_read      (rx_read),
    .key_event    (rx_event),
    .shift_key_on (rx_shift_key_on),
    .data_ready   (rx_data_ready)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_ps2_keyboard_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ps2_params.svh"

module tb_ps2_keyboard_rx;

  localparam int half_bit_clocks = 10; // system clocks per ps2 clock half period
  localparam int frame_clocks    = 2 * half_bit_clocks * `PS2_FRAME_BITS;
  localparam int ready_timeout   = 40 * frame_clocks;

  // set 2 make codes, index is the letter or digit value
  localparam ps2_frame_pkg::scan_code_t letter_codes [26] = '{
    8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A,
    8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
  localparam ps2_frame_pkg::scan_code_t digit_codes [10] = '{
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};

  logic                    clk;
  logic                    reset;
  logic                    ps2_clk;
  logic                    ps2_data;
  logic                    rx_read;
  ps2_key_pkg::key_event_t rx_event;
  logic                    rx_shift_key_on;
  logic                    rx_data_ready;

  logic model_extended;    // E0 held
  logic model_released;    // F0 held
  logic model_left_shift;
  logic model_right_shift;
  logic hold_ready_check;  // a key sits unread, ready must stay up

  ps2_keyboard_rx #(
    .trap_shift_keys (0)
  ) i_dut (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_read         (rx_read),
    .rx_event        (rx_event),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_data_ready   (rx_data_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_event(input ps2_key_pkg::key_event_t actual,
                             input ps2_key_pkg::key_event_t expected);
    if (actual !== expected)
    begin
      $write("FAIL %0t rx_event got ext=%b rel=%b code=%h ascii=%h", $time,
             actual.extended, actual.released, actual.scan_code, actual.ascii);
      $display(" expected ext=%b rel=%b code=%h ascii=%h",
               expected.extended, expected.released, expected.scan_code, expected.ascii);
      $display("Testbench failed");
      $fatal(1, "key event mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("FAIL %0t %s got %b expected %b", $time, name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "status bit mismatch");
    end
  endtask

  always @(posedge clk)
  begin
    if (hold_ready_check)
      check_bit("rx_data_ready", rx_data_ready, 1'b1); // back-pressure, no drop allowed
  end

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic ps2_key_pkg::ascii_t model_ascii(input ps2_frame_pkg::scan_code_t code,
                                                      input logic shift);
    ps2_key_pkg::ascii_t result;
    int i;
    result = `PS2_UNKNOWN_ASCII;
    for (i = 0; i < 26; i++)
      if (letter_codes[i] == code)
        result = shift ? 8'(65 + i) : 8'(97 + i); // 'A' or 'a'
    for (i = 0; i < 10; i++)
      if (!shift && digit_codes[i] == code)
        result = 8'(48 + i); // shifted digits stay '.'
    case (code)
      8'h66: result = 8'h08; // backspace
      8'h0D: result = 8'h09; // tab
      8'h5A: result = 8'h0D; // enter
      8'h76: result = 8'h1B; // escape
      8'h29: result = 8'h20; // space
      default: ;
    endcase
    return result;
  endfunction

  function automatic ps2_frame_pkg::frame_t make_frame(input ps2_frame_pkg::scan_code_t code);
    return {1'b1, ~^code, code, 1'b0}; // stop, odd parity, data, start
  endfunction

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic wait_cycles(input int count);
    repeat (count) @(posedge clk);
  endtask

  // data moves mid clock high, then the clock drops
  task automatic send_bits(input ps2_frame_pkg::frame_t bits, input int count);
    int i;
    for (i = 0; i < count; i++)
    begin
      wait_cycles(half_bit_clocks / 2);
      ps2_data <= bits[i];
      wait_cycles(half_bit_clocks - half_bit_clocks / 2);
      ps2_clk <= 1'b0;
      wait_cycles(half_bit_clocks);
      ps2_clk <= 1'b1;
    end
    wait_cycles(half_bit_clocks);
    ps2_data <= 1'b1; // lines left idle high
  endtask

  task automatic wait_ready;
    int waited;
    waited = 0;
    @(negedge clk);
    while (!rx_data_ready && waited < ready_timeout)
    begin
      @(negedge clk);
      waited++;
    end
    if (!rx_data_ready)
    begin
      $display("timed out after %0d cycles waiting for rx_data_ready", waited);
      $display("Testbench failed");
      $fatal(1, "ready timeout");
    end
  endtask

  task automatic read_key;
    @(posedge clk);
    rx_read <= 1'b1;
    @(posedge clk);
    rx_read <= 1'b0;
    @(negedge clk);
    check_bit("rx_data_ready", rx_data_ready, 1'b0); // dropped one cycle after the strobe
  endtask

  // sends one code, steps the model and checks what the DUT reports
  task automatic type_code(input ps2_frame_pkg::scan_code_t code, input logic read_after);
    ps2_key_pkg::key_event_t expected;
    logic reported;
    reported = 1'b0;
    expected = '0;
    if (code == `PS2_EXTEND_CODE)
      model_extended = 1'b1;
    else if (code == `PS2_RELEASE_CODE)
      model_released = 1'b1;
    else
    begin
      expected.extended  = model_extended;
      expected.released  = model_released;
      expected.scan_code = code;
      expected.ascii     = model_ascii(code, model_left_shift || model_right_shift);
      reported = 1'b1;
      if (code == `PS2_LEFT_SHIFT)
        model_left_shift = !model_released;
      if (code == `PS2_RIGHT_SHIFT)
        model_right_shift = !model_released;
      model_extended = 1'b0;
      model_released = 1'b0;
    end
    send_bits(make_frame(code), `PS2_FRAME_BITS);
    if (reported)
    begin
      wait_ready;
      check_event(rx_event, expected);
    end
    else
    begin
      @(negedge clk);
      check_bit("rx_data_ready", rx_data_ready, 1'b0); // prefix alone, no event
    end
    check_bit("rx_shift_key_on", rx_shift_key_on, model_left_shift || model_right_shift);
    if (reported && read_after)
      read_key;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    logic [31:0]               rnd;
    ps2_frame_pkg::scan_code_t code;
    int                        n;
    reset             = 1'b1;
    ps2_clk           = 1'b1;
    ps2_data          = 1'b1;
    rx_read           = 1'b0;
    hold_ready_check  = 1'b0;
    model_extended    = 1'b0;
    model_released    = 1'b0;
    model_left_shift  = 1'b0;
    model_right_shift = 1'b0;
    rnd = $urandom(71719); // seeds the generator once
    wait_cycles(5);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("rx_data_ready", rx_data_ready, 1'b0);
    check_bit("rx_shift_key_on", rx_shift_key_on, 1'b0);
    check_event(rx_event, '0);

    // random plain keys, prefix and shift codes nudged aside
    for (n = 0; n < 200; n++)
    begin
      rnd  = $urandom;
      code = rnd[7:0];
      if (code == `PS2_EXTEND_CODE || code == `PS2_RELEASE_CODE
          || code == `PS2_LEFT_SHIFT || code == `PS2_RIGHT_SHIFT)
        code = code ^ 8'h01;
      type_code(code, 1'b1);
    end

    type_code(`PS2_EXTEND_CODE, 1'b1); // extended key
    type_code(8'h75, 1'b1);
    type_code(`PS2_RELEASE_CODE, 1'b1); // break of a letter
    type_code(8'h1C, 1'b1);
    type_code(`PS2_EXTEND_CODE, 1'b1); // extended break
    type_code(`PS2_RELEASE_CODE, 1'b1);
    type_code(8'h75, 1'b1);
    type_code(8'h1C, 1'b1); // flags must not carry over

    // shift, left then right
    type_code(`PS2_LEFT_SHIFT, 1'b1);
    type_code(8'h1C, 1'b1);
    type_code(8'h32, 1'b1);
    type_code(8'h16, 1'b1);
    type_code(`PS2_RELEASE_CODE, 1'b1);
    type_code(`PS2_LEFT_SHIFT, 1'b1);
    type_code(`PS2_RIGHT_SHIFT, 1'b1);
    type_code(8'h1A, 1'b1);
    type_code(8'h45, 1'b1);
    type_code(`PS2_RELEASE_CODE, 1'b1);
    type_code(`PS2_RIGHT_SHIFT, 1'b1);
    type_code(8'h1A, 1'b1);

    // back-pressure, second key overwrites the first
    type_code(8'h1C, 1'b0);
    hold_ready_check = 1'b1;
    type_code(8'h32, 1'b0);
    hold_ready_check = 1'b0;
    read_key;

    // half a frame, then a stall longer than the watchdog
    send_bits(make_frame(8'h1C), 5); // start plus four data bits
    wait_cycles(`PS2_WATCHDOG_CYCLES + 100);
    @(negedge clk);
    check_bit("rx_data_ready", rx_data_ready, 1'b0);
    type_code(8'h24, 1'b1);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ps2_keyboard_rx.f ====
+incdir+include
design/ps2_frame_pkg.sv
design/ps2_key_pkg.sv
design/ps2_ascii_map.sv
design/ps2_rx_frame.sv
design/ps2_key_decoder.sv
design/ps2_keyboard_rx.sv
testbench/tb_ps2_keyboard_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
verilator --binary --timing --assert --top-module tb_ps2_keyboard_rx \
  -f ps2_keyboard_rx.f -o tb_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "Testbench passed" && exit 0 || exit 1
